// ==== include/mem_sys_defines.svh ====
`ifndef MEM_SYS_DEFINES_SVH
`define MEM_SYS_DEFINES_SVH

// Address map, taken from byte address bits 31..28
`define MEM_SYS_REGION_CODE 4'h1
`define MEM_SYS_REGION_DATA 4'h2
`define MEM_SYS_REGION_PIM  4'h4

// Words per memory, 4 KB each
`define MEM_SYS_MEM_WORDS 1024

// Request queue entries, also the host's starting credit count
`define MEM_SYS_REQ_DEPTH 4

`endif

// ==== verilog/mem_sys_pkg.sv ====
package mem_sys_pkg;

    // Byte address on the system bus
    typedef logic [31:0] addr_t;

    // Bus data word
    typedef logic [31:0] data_t;

    // Byte enables, bit k covers the byte at address + k
    typedef logic [3:0] byte_en_t;

    // Word index into one memory bank
    typedef logic [9:0] bank_addr_t;

    // Region code from address bits 31..28
    typedef logic [3:0] region_t;

    // One bus request as the host sends it
    typedef struct packed {
        addr_t    addr;
        data_t    wdata;
        byte_en_t size;
        logic     write;
    } mem_req_t;

endpackage

// ==== verilog/req_fifo.sv ====
`timescale 1ns/1ns
`include "mem_sys_defines.svh"

module req_fifo #(
    parameter int DEPTH = `MEM_SYS_REQ_DEPTH
) (
    input  logic                  clk_i,
    input  logic                  rv_rst_ni,
    input  logic                  push_i,
    input  mem_sys_pkg::mem_req_t push_req_i,
    output logic                  issue_valid_o,
    output mem_sys_pkg::mem_req_t issue_req_o,
    output logic                  credit_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_sys_pkg::mem_req_t entry_q [DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [CNT_W-1:0]      count_q;
    logic                  pop;

    // Oldest entry goes out every cycle the queue holds something
    assign pop           = (count_q != '0);
    assign issue_valid_o = pop;
    assign issue_req_o   = entry_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            entry_q[wr_ptr_q] <= push_req_i;
        end
    end

    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q  <= count_q + CNT_W'(push_i) - CNT_W'(pop);
            // One credit back per issued entry
            credit_o <= pop;
        end
    end

    // Host credit accounting must keep it off a full queue
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rv_rst_ni)
        push_i |-> (count_q != CNT_W'(DEPTH)));

    a_count_range: assert property (@(posedge clk_i) disable iff (!rv_rst_ni)
        count_q <= CNT_W'(DEPTH));

endmodule

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/1ns
`include "mem_sys_defines.svh"

module bus_decoder (
    input  logic                  clk_i,
    input  logic                  rv_rst_ni,
    input  logic                  issue_valid_i,
    input  mem_sys_pkg::mem_req_t issue_req_i,
    output mem_sys_pkg::mem_req_t tgt_req_o,
    output logic                  code_sel_o,
    output logic                  data_sel_o,
    output logic                  pim_sel_o,
    input  mem_sys_pkg::data_t    code_rdata_i,
    input  mem_sys_pkg::data_t    data_rdata_i,
    input  mem_sys_pkg::data_t    pim_rdata_i,
    output logic                  rsp_valid_o,
    output mem_sys_pkg::data_t    rsp_data_o
);

    mem_sys_pkg::region_t region;
    mem_sys_pkg::region_t region_q;
    logic                 pending_q;

    assign region    = issue_req_i.addr[31:28];
    // All slaves see the same request, only the select differs
    assign tgt_req_o = issue_req_i;

    assign code_sel_o = issue_valid_i && (region == `MEM_SYS_REGION_CODE);
    assign data_sel_o = issue_valid_i && (region == `MEM_SYS_REGION_DATA);
    assign pim_sel_o  = issue_valid_i && (region == `MEM_SYS_REGION_PIM);

    // Remember which slave owes a read word next cycle
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            pending_q <= 1'b0;
            region_q  <= '0;
        end else begin
            pending_q <= issue_valid_i && !issue_req_i.write;
            if (issue_valid_i) begin
                region_q <= region;
            end
        end
    end

    assign rsp_valid_o = pending_q;

    // Return mux, unmapped regions read as zero
    always_comb begin
        case (region_q)
            `MEM_SYS_REGION_CODE: begin
                rsp_data_o = code_rdata_i;
            end
            `MEM_SYS_REGION_DATA: begin
                rsp_data_o = data_rdata_i;
            end
            `MEM_SYS_REGION_PIM: begin
                rsp_data_o = pim_rdata_i;
            end
            default: begin
                rsp_data_o = '0;
            end
        endcase
    end

    // Issued request fully driven
    a_issue_known: assert property (@(posedge clk_i) disable iff (!rv_rst_ni)
        issue_valid_i |-> !$isunknown(issue_req_i));

endmodule

// ==== verilog/code_mem.sv ====
`timescale 1ns/1ns
`include "mem_sys_defines.svh"

module code_mem (
    input  logic                  clk_i,
    input  logic                  sel_i,
    input  mem_sys_pkg::mem_req_t req_i,
    output mem_sys_pkg::data_t    rdata_o
);

    logic [7:0]               bank_q [4][`MEM_SYS_MEM_WORDS];
    mem_sys_pkg::bank_addr_t  word;
    mem_sys_pkg::bank_addr_t  idx [4];
    logic [1:0]               lane [4];
    logic [1:0]               low;
    logic [1:0]               low_q;
    logic [3:0][7:0]          dout_q;

    assign word = req_i.addr[11:2];
    assign low  = req_i.addr[1:0];

    // Bank b holds bytes whose address ends in b. Byte lane of the request
    // that lands in bank b, and the bank's word index with the carry into
    // the next word for banks below the start offset
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            lane[b] = 2'(b) - low;
            idx[b]  = word + mem_sys_pkg::bank_addr_t'(2'(b) < low);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (sel_i && req_i.write && req_i.size[lane[b]]) begin
                bank_q[b][idx[b]] <= req_i.wdata[8*lane[b] +: 8];
            end
        end
        if (sel_i && !req_i.write) begin
            low_q <= low;
            for (int b = 0; b < 4; b++) begin
                dout_q[b] <= bank_q[b][idx[b]];
            end
        end
    end

    // Rotate bank outputs back so the lowest address is byte 0
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rdata_o[8*k +: 8] = dout_q[2'(low_q + 2'(k))];
        end
    end

endmodule

// ==== verilog/data_mem.sv ====
`timescale 1ns/1ns
`include "mem_sys_defines.svh"

module data_mem (
    input  logic                  clk_i,
    input  logic                  sel_i,
    input  mem_sys_pkg::mem_req_t req_i,
    output mem_sys_pkg::data_t    rdata_o
);

    mem_sys_pkg::data_t      mem_q [`MEM_SYS_MEM_WORDS];
    mem_sys_pkg::bank_addr_t idx;

    // Word addressed, byte offset bits are dropped
    assign idx = req_i.addr[11:2];

    always_ff @(posedge clk_i) begin
        if (sel_i && req_i.write) begin
            for (int k = 0; k < 4; k++) begin
                if (req_i.size[k]) begin
                    mem_q[idx][8*k +: 8] <= req_i.wdata[8*k +: 8];
                end
            end
        end
        // Read word held until the next selected read
        if (sel_i && !req_i.write) begin
            rdata_o <= mem_q[idx];
        end
    end

endmodule

// ==== verilog/pim_port.sv ====
`timescale 1ns/1ns

module pim_port (
    input  logic                  clk_i,
    input  logic                  rv_rst_ni,
    input  logic                  sel_i,
    input  mem_sys_pkg::mem_req_t req_i,
    input  mem_sys_pkg::data_t    pim_rd_i,
    output mem_sys_pkg::data_t    rdata_o,
    output mem_sys_pkg::addr_t    pim_addr_o,
    output mem_sys_pkg::data_t    pim_wr_o
);

    // Controller outputs, loaded by a write to the PIM region
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            pim_addr_o <= '0;
            pim_wr_o   <= '0;
        end else if (sel_i && req_i.write) begin
            pim_addr_o <= req_i.addr;
            pim_wr_o   <= req_i.wdata;
        end
    end

    // Sample of the controller input taken in the issue cycle
    always_ff @(posedge clk_i) begin
        if (sel_i && !req_i.write) begin
            rdata_o <= pim_rd_i;
        end
    end

endmodule

// ==== verilog/mem_sys_top.sv ====
`timescale 1ns/1ns

module mem_sys_top (
    input  logic                  clk_i,
    input  logic                  rv_rst_ni,
    input  logic                  req_valid_i,
    input  mem_sys_pkg::mem_req_t req_i,
    output logic                  credit_o,
    output logic                  rsp_valid_o,
    output mem_sys_pkg::data_t    rsp_data_o,
    output mem_sys_pkg::addr_t    pim_addr_o,
    output mem_sys_pkg::data_t    pim_wr_o,
    input  mem_sys_pkg::data_t    pim_rd_i
);

    logic                  issue_valid;
    mem_sys_pkg::mem_req_t issue_req;
    mem_sys_pkg::mem_req_t tgt_req;
    logic                  code_sel;
    logic                  data_sel;
    logic                  pim_sel;
    mem_sys_pkg::data_t    code_rdata;
    mem_sys_pkg::data_t    data_rdata;
    mem_sys_pkg::data_t    pim_rdata;

    // Host request queue
    req_fifo req_fifo_i (
        .clk_i         (clk_i),
        .rv_rst_ni     (rv_rst_ni),
        .push_i        (req_valid_i),
        .push_req_i    (req_i),
        .issue_valid_o (issue_valid),
        .issue_req_o   (issue_req),
        .credit_o      (credit_o)
    );

    bus_decoder bus_decoder_i (
        .clk_i         (clk_i),
        .rv_rst_ni     (rv_rst_ni),
        .issue_valid_i (issue_valid),
        .issue_req_i   (issue_req),
        .tgt_req_o     (tgt_req),
        .code_sel_o    (code_sel),
        .data_sel_o    (data_sel),
        .pim_sel_o     (pim_sel),
        .code_rdata_i  (code_rdata),
        .data_rdata_i  (data_rdata),
        .pim_rdata_i   (pim_rdata),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_data_o    (rsp_data_o)
    );

    // Slaves
    code_mem code_mem_i (
        .clk_i   (clk_i),
        .sel_i   (code_sel),
        .req_i   (tgt_req),
        .rdata_o (code_rdata)
    );

    data_mem data_mem_i (
        .clk_i   (clk_i),
        .sel_i   (data_sel),
        .req_i   (tgt_req),
        .rdata_o (data_rdata)
    );

    pim_port pim_port_i (
        .clk_i      (clk_i),
        .rv_rst_ni  (rv_rst_ni),
        .sel_i      (pim_sel),
        .req_i      (tgt_req),
        .pim_rd_i   (pim_rd_i),
        .rdata_o    (pim_rdata),
        .pim_addr_o (pim_addr_o),
        .pim_wr_o   (pim_wr_o)
    );

endmodule

// ==== tests/tb_mem_sys.sv ====
`timescale 1ns/1ns
`include "mem_sys_defines.svh"

module tb_mem_sys;

    localparam int DEPTH   = `MEM_SYS_REQ_DEPTH;
    localparam int TIMEOUT = 200;
    localparam int NUM_OPS = 800;

    logic                  clk_i;
    logic                  rv_rst_ni;
    logic                  req_valid_i;
    mem_sys_pkg::mem_req_t req_i;
    logic                  credit_o;
    logic                  rsp_valid_o;
    mem_sys_pkg::data_t    rsp_data_o;
    mem_sys_pkg::addr_t    pim_addr_o;
    mem_sys_pkg::data_t    pim_wr_o;
    mem_sys_pkg::data_t    pim_rd_i;

    logic [31:0]        lfsr;
    int                 credits;
    int                 data_errs;
    int                 addr_errs;
    int                 proto_errs;
    logic [7:0]         code_model [4096];
    mem_sys_pkg::data_t data_model [`MEM_SYS_MEM_WORDS];
    mem_sys_pkg::data_t exp_q [$];
    string              name_q [$];

    mem_sys_top mem_sys_top_i (
        .clk_i       (clk_i),
        .rv_rst_ni   (rv_rst_ni),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .credit_o    (credit_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o),
        .pim_addr_o  (pim_addr_o),
        .pim_wr_o    (pim_wr_o),
        .pim_rd_i    (pim_rd_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Initial memory contents, a function of the full byte address
    function automatic mem_sys_pkg::data_t fill_word(input mem_sys_pkg::addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5ac3_96e1;
    endfunction

    // Mapped regions for kinds 0..5, one of four unmapped codes otherwise
    function automatic mem_sys_pkg::region_t region_for(input logic [2:0] kind,
                                                        input logic [1:0] pick);
        case (kind)
            3'd0, 3'd1, 3'd2: return `MEM_SYS_REGION_CODE;
            3'd3, 3'd4: return `MEM_SYS_REGION_DATA;
            3'd5: return `MEM_SYS_REGION_PIM;
            default: begin
                case (pick)
                    2'd0: return 4'h0;
                    2'd1: return 4'h3;
                    2'd2: return 4'h8;
                    default: return 4'hf;
                endcase
            end
        endcase
    endfunction

    task automatic report_counts();
        $display("errors: data %0d, addr %0d, protocol %0d", data_errs, addr_errs, proto_errs);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        report_counts();
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check_data(input string name, input mem_sys_pkg::data_t exp,
                              input mem_sys_pkg::data_t act);
        if (act !== exp) begin
            data_errs++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input mem_sys_pkg::addr_t exp,
                              input mem_sys_pkg::addr_t act);
        if (act !== exp) begin
            addr_errs++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // Push one request, waiting for a credit first
    task automatic send(input mem_sys_pkg::mem_req_t req);
        int cnt;
        cnt = 0;
        while (credits == 0 && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        if (credits == 0) begin
            abort_run("timeout: no credit came back from the request queue");
        end else begin
            credits--;
            req_valid_i = 1'b1;
            req_i       = req;
            next_cycle();
            req_valid_i = 1'b0;
        end
    endtask

    // All credits home and no read outstanding
    task automatic drain();
        int cnt;
        cnt = 0;
        while ((credits != DEPTH || exp_q.size() != 0) && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        if (credits != DEPTH || exp_q.size() != 0) begin
            abort_run("timeout: outstanding requests did not drain");
        end
    endtask

    // Apply the request to the model in order, then send it
    task automatic do_request(input mem_sys_pkg::mem_req_t req);
        logic [11:0]        a;
        logic [11:0]        ba;
        mem_sys_pkg::data_t exp;
        string              nm;
        a   = req.addr[11:0];
        exp = '0;
        nm  = "unmapped read";
        case (req.addr[31:28])
            `MEM_SYS_REGION_CODE: begin
                nm = "code read";
                for (int k = 0; k < 4; k++) begin
                    ba = a + 12'(k);
                    if (req.write && req.size[k]) begin
                        code_model[ba] = req.wdata[8*k +: 8];
                    end
                    exp[8*k +: 8] = code_model[ba];
                end
            end
            `MEM_SYS_REGION_DATA: begin
                nm = "data read";
                for (int k = 0; k < 4; k++) begin
                    if (req.write && req.size[k]) begin
                        data_model[a[11:2]][8*k +: 8] = req.wdata[8*k +: 8];
                    end
                end
                exp = data_model[a[11:2]];
            end
            `MEM_SYS_REGION_PIM: begin
                nm = "pim read";
                if (!req.write) begin
                    // Input only changes with no read in flight
                    drain();
                    pim_rd_i = rand_bits(32);
                    exp      = pim_rd_i;
                end
            end
            default: begin
                exp = '0;
            end
        endcase
        if (!req.write) begin
            exp_q.push_back(exp);
            name_q.push_back(nm);
        end
        send(req);
        if (req.write && req.addr[31:28] == `MEM_SYS_REGION_PIM) begin
            drain();
            check_addr("pim addr", req.addr, pim_addr_o);
            check_data("pim wdata", req.wdata, pim_wr_o);
        end
    endtask

    // Credit and response monitor, sampled mid cycle
    always @(negedge clk_i) begin
        if (credit_o === 1'b1) begin
            credits++;
            if (credits > DEPTH) begin
                proto_errs++;
                $display("credit returned with no request outstanding");
            end
        end
        if (rsp_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                proto_errs++;
                $display("response arrived with no read outstanding");
            end else begin
                check_data(name_q.pop_front(), exp_q.pop_front(), rsp_data_o);
            end
        end
    end

    initial begin
        mem_sys_pkg::mem_req_t req;
        logic [2:0]            kind;
        lfsr        = 32'hb67e;
        credits     = DEPTH;
        data_errs   = 0;
        addr_errs   = 0;
        proto_errs  = 0;
        rv_rst_ni   = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        pim_rd_i    = '0;
        repeat (8) @(posedge clk_i);
        #1 rv_rst_ni = 1'b1;

        // Quiet bus after reset
        repeat (4) begin
            @(negedge clk_i);
            if (credit_o !== 1'b0 || rsp_valid_o !== 1'b0) begin
                proto_errs++;
                $display("credit or response active after reset with no request sent");
            end
        end
        next_cycle();

        // Preload both memories with full-word writes
        for (int i = 0; i < `MEM_SYS_MEM_WORDS; i++) begin
            req.write = 1'b1;
            req.size  = 4'hf;
            req.addr  = {`MEM_SYS_REGION_CODE, 16'h0, 10'(i), 2'b00};
            req.wdata = fill_word(req.addr);
            do_request(req);
            req.addr[31:28] = `MEM_SYS_REGION_DATA;
            req.wdata       = fill_word(req.addr);
            do_request(req);
        end

        for (int n = 0; n < NUM_OPS; n++) begin
            kind      = 3'(rand_bits(3));
            req.write = 1'(rand_bits(1));
            req.addr  = {4'h0, 16'(rand_bits(16)), 12'(rand_bits(12))};
            req.wdata = rand_bits(32);
            req.size  = 4'(rand_bits(4));
            req.addr[31:28] = region_for(kind, 2'(rand_bits(2)));
            // Start in the last three bytes so the word wraps to byte 0
            if (kind == 3'd2) begin
                req.addr[11:0] = 12'hffd + 12'(rand_bits(2) % 3);
            end
            do_request(req);
        end

        drain();
        repeat (4) next_cycle();

        report_counts();
        if (data_errs + addr_errs + proto_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
verilog/mem_sys_pkg.sv
verilog/req_fifo.sv
verilog/bus_decoder.sv
verilog/code_mem.sv
verilog/data_mem.sv
verilog/pim_port.sv
verilog/mem_sys_top.sv
tests/tb_mem_sys.sv
